//--- design/operand_buf.sv
module operand_buf (
    input  logic                                         clk,
    input  logic                                         sys_rst,
    input  logic                                         wr,
    input  logic                                         wr_sel,   // 0 = A, 1 = B
    input  logic [sa_pkg::sa_idx_w-1:0]                  wr_row,
    input  logic [sa_pkg::sa_idx_w-1:0]                  wr_col,
    input  logic [sa_pkg::sa_in_w-1:0]                   wr_data,
    input  logic                                         busy,
    input  logic [sa_pkg::sa_idx_w-1:0]                  rd_idx,
    input  logic                                         rd_en,
    output logic [sa_pkg::sa_n-1:0][sa_pkg::sa_in_w-1:0] a_col,
    output logic [sa_pkg::sa_n-1:0][sa_pkg::sa_in_w-1:0] b_row
);

    logic [sa_pkg::sa_in_w-1:0] mem_a [sa_pkg::sa_n][sa_pkg::sa_n]; // [row][col]
    logic [sa_pkg::sa_in_w-1:0] mem_b [sa_pkg::sa_n][sa_pkg::sa_n];
    logic                       wr_ok;

    assign wr_ok = wr && !busy && !sys_rst;     // frozen during a run

    always_ff @(posedge clk) begin
        if (wr_ok && !wr_sel) begin
            mem_a[wr_row][wr_col] <= wr_data;
        end
        if (wr_ok && wr_sel) begin
            mem_b[wr_row][wr_col] <= wr_data;
        end
    end

    // ####################
    // read side
    // ####################
    always_comb begin
        for (int i = 0; i < sa_pkg::sa_n; i++) begin
            if (rd_en) begin
                a_col[i] = mem_a[i][rd_idx];     // lane i gets A[i][k]
                b_row[i] = mem_b[rd_idx][i];     // lane i gets B[k][i]
            end else begin
                a_col[i] = '0;
                b_row[i] = '0;
            end
        end
    end

endmodule

//--- design/operand_skew.sv
module operand_skew (
    input  logic   clk,
    input  logic   sys_rst,
    sa_feed_if.skew in,
    sa_feed_if.src  out
);

    // strobes enter only PE(0,0), so no delay here
    assign out.cal_en   = in.cal_en;
    assign out.cal_done = in.cal_done;

    assign out.row_data[0] = in.row_data[0];
    assign out.col_data[0] = in.col_data[0];

    // ####################
    // lane i gets an i deep shift register
    // ####################
    for (genvar i = 1; i < sa_pkg::sa_n; i++) begin : g_lane
        logic [sa_pkg::sa_in_w-1:0] row_sr [i];
        logic [sa_pkg::sa_in_w-1:0] col_sr [i];

        always_ff @(posedge clk) begin
            if (sys_rst) begin
                for (int k = 0; k < i; k++) begin
                    row_sr[k] <= '0;
                    col_sr[k] <= '0;
                end
            end else begin
                row_sr[0] <= in.row_data[i];
                col_sr[0] <= in.col_data[i];
                for (int k = 1; k < i; k++) begin
                    row_sr[k] <= row_sr[k-1];
                    col_sr[k] <= col_sr[k-1];
                end
            end
        end

        assign out.row_data[i] = row_sr[i-1];
        assign out.col_data[i] = col_sr[i-1];
    end

endmodule

//--- design/pe_array.sv
module pe_array (
    input  logic                                          clk,
    input  logic                                          sys_rst,
    sa_feed_if.pe                                         feed,
    output logic [sa_pkg::sa_n-1:0]                       col_val,
    output logic [sa_pkg::sa_n-1:0][sa_pkg::sa_out_w-1:0] col_data
);

    logic [sa_pkg::sa_in_w-1:0]  west_op  [sa_pkg::sa_n][sa_pkg::sa_n+1]; // last column unused
    logic [sa_pkg::sa_in_w-1:0]  north_op [sa_pkg::sa_n+1][sa_pkg::sa_n];
    logic                        en_in    [sa_pkg::sa_n][sa_pkg::sa_n];
    logic                        done_in  [sa_pkg::sa_n][sa_pkg::sa_n];
    logic                        en_out   [sa_pkg::sa_n][sa_pkg::sa_n];
    logic                        done_out [sa_pkg::sa_n][sa_pkg::sa_n];
    logic                        res_v    [sa_pkg::sa_n+1][sa_pkg::sa_n]; // row n is the tie-off
    logic [sa_pkg::sa_out_w-1:0] res_d    [sa_pkg::sa_n+1][sa_pkg::sa_n];

    // ####################
    // array edges
    // ####################
    for (genvar i = 0; i < sa_pkg::sa_n; i++) begin : g_edge
        assign west_op[i][0]          = feed.row_data[i];
        assign north_op[0][i]         = feed.col_data[i];
        assign res_v[sa_pkg::sa_n][i] = 1'b0;
        assign res_d[sa_pkg::sa_n][i] = '0;
        assign col_val[i]             = res_v[0][i];
        assign col_data[i]            = res_d[0][i];
    end

    for (genvar r = 0; r < sa_pkg::sa_n; r++) begin : g_row
        for (genvar c = 0; c < sa_pkg::sa_n; c++) begin : g_col
            // strobes run down column 0, then east along each row
            if (c > 0) begin : g_from_west
                assign en_in[r][c]   = en_out[r][c-1];
                assign done_in[r][c] = done_out[r][c-1];
            end else if (r > 0) begin : g_from_north
                assign en_in[r][c]   = en_out[r-1][0];
                assign done_in[r][c] = done_out[r-1][0];
            end else begin : g_corner
                assign en_in[r][c]   = feed.cal_en;
                assign done_in[r][c] = feed.cal_done;
            end

            pe_mac i_pe_mac (
                .clk        (clk),
                .sys_rst    (sys_rst),
                .cal_en     (en_in[r][c]),
                .cal_done   (done_in[r][c]),
                .westin     (west_op[r][c]),
                .northin    (north_op[r][c]),
                .din_val    (res_v[r+1][c]),
                .din        (res_d[r+1][c]),
                .n_cal_en   (en_out[r][c]),
                .n_cal_done (done_out[r][c]),
                .eastout    (west_op[r][c+1]),
                .southout   (north_op[r+1][c]),
                .dout_val   (res_v[r][c]),
                .dout       (res_d[r][c])
            );
        end
    end

endmodule

//--- design/pe_mac.sv
module pe_mac (
    input  logic                         clk,
    input  logic                         sys_rst,
    input  logic                         cal_en,
    input  logic                         cal_done,
    input  logic [sa_pkg::sa_in_w-1:0]   westin,
    input  logic [sa_pkg::sa_in_w-1:0]   northin,
    input  logic                         din_val,
    input  logic [sa_pkg::sa_out_w-1:0]  din,
    output logic                         n_cal_en,
    output logic                         n_cal_done,
    output logic [sa_pkg::sa_in_w-1:0]   eastout,
    output logic [sa_pkg::sa_in_w-1:0]   southout,
    output logic                         dout_val,
    output logic [sa_pkg::sa_out_w-1:0]  dout
);

    logic [sa_pkg::sa_out_w-1:0] product;
    logic [sa_pkg::sa_out_w-1:0] partial_sum;

    // ####################
    // strobes and result valid
    // ####################
    always_ff @(posedge clk) begin
        if (sys_rst) begin
            n_cal_en   <= 1'b0;
            n_cal_done <= 1'b0;
            dout_val   <= 1'b0;
        end else begin
            n_cal_en   <= cal_en;
            n_cal_done <= cal_done;
            dout_val   <= cal_done | din_val;        // own sum or one from below
        end
    end

    // ####################
    // multiply accumulate
    // ####################
    always_ff @(posedge clk) begin
        if (cal_en) begin
            product <= sa_pkg::sa_out_w'(westin) * sa_pkg::sa_out_w'(northin);
        end else begin
            product <= '0;
        end

        // product lags one cycle, so the first add takes zero
        if (cal_en && !cal_done) begin
            partial_sum <= partial_sum + product;
        end else begin
            partial_sum <= '0;
        end

        if (cal_done) begin
            dout <= partial_sum + product;           // flush the last product
        end else if (din_val) begin
            dout <= din;                             // pass a result north
        end else begin
            dout <= '0;
        end
    end

    // operand forwarding
    always_ff @(posedge clk) begin
        if (cal_en) begin
            eastout  <= westin;
            southout <= northin;
        end else begin
            eastout  <= '0;
            southout <= '0;
        end
    end

    // the finish strobe must land inside the window of its own run
    a_done_in_window: assert property (@(posedge clk) disable iff (sys_rst)
        cal_done |-> cal_en);

endmodule

//--- design/result_collect.sv
module result_collect (
    input  logic                                          clk,
    input  logic                                          sys_rst,
    input  logic [sa_pkg::sa_n-1:0]                       col_val,
    input  logic [sa_pkg::sa_n-1:0][sa_pkg::sa_out_w-1:0] col_data,
    output logic [sa_pkg::sa_n-1:0]                       res_val,
    output logic [sa_pkg::sa_n-1:0][sa_pkg::sa_idx_w-1:0] res_row,
    output logic [sa_pkg::sa_n-1:0][sa_pkg::sa_out_w-1:0] res_data,
    output logic                                          frame_end
);

    logic [sa_pkg::sa_n-1:0][sa_pkg::sa_idx_w-1:0] row_cnt;  // rows arrive in order 0..n-1
    logic [sa_pkg::sa_cnt_w-1:0]                   total;
    logic [sa_pkg::sa_cnt_w-1:0]                   total_nxt;
    logic                                          last;

    always_comb begin
        total_nxt = total;
        for (int c = 0; c < sa_pkg::sa_n; c++) begin
            total_nxt = total_nxt + sa_pkg::sa_cnt_w'(col_val[c]);
        end
    end

    assign last = (total_nxt == sa_pkg::sa_cnt_w'(sa_pkg::sa_n * sa_pkg::sa_n));

    always_ff @(posedge clk) begin
        if (sys_rst) begin
            res_val   <= '0;
            frame_end <= 1'b0;
            total     <= '0;
            row_cnt   <= '0;
        end else begin
            res_val   <= col_val;
            frame_end <= last;                  // lines up with the final res_val
            total     <= last ? '0 : total_nxt;
            for (int c = 0; c < sa_pkg::sa_n; c++) begin
                if (col_val[c]) begin
                    row_cnt[c] <= (row_cnt[c] == sa_pkg::sa_idx_w'(sa_pkg::sa_n - 1)) ?
                                  '0 : row_cnt[c] + sa_pkg::sa_idx_w'(1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        res_data <= col_data;
        res_row  <= row_cnt;                    // tag before the counter steps
    end

    for (genvar c = 0; c < sa_pkg::sa_n; c++) begin : g_chk
        a_row_range: assert property (@(posedge clk) disable iff (sys_rst)
            row_cnt[c] <= sa_pkg::sa_idx_w'(sa_pkg::sa_n - 1));
        // every column has delivered exactly n results when the frame closes
        a_col_complete: assert property (@(posedge clk) disable iff (sys_rst)
            frame_end |-> row_cnt[c] == '0);
    end

endmodule

//--- design/sa_ctrl.sv
module sa_ctrl (
    input  logic                                         clk,
    input  logic                                         sys_rst,
    input  logic                                         start,
    input  logic                                         frame_end,
    input  logic [sa_pkg::sa_n-1:0][sa_pkg::sa_in_w-1:0] a_col,
    input  logic [sa_pkg::sa_n-1:0][sa_pkg::sa_in_w-1:0] b_row,
    output logic                                         busy,
    output logic                                         done,
    output logic [sa_pkg::sa_idx_w-1:0]                  rd_idx,
    output logic                                         rd_en,
    sa_feed_if.src                                       feed
);

    sa_pkg::sa_state_e           state;
    sa_pkg::sa_state_e           state_nxt;
    logic [sa_pkg::sa_idx_w-1:0] cnt;

    always_comb begin
        state_nxt = state;
        case (state)
            sa_pkg::st_idle:   if (start) state_nxt = sa_pkg::st_feed;
            sa_pkg::st_feed: begin
                if (cnt == sa_pkg::sa_idx_w'(sa_pkg::sa_n - 1)) begin
                    state_nxt = sa_pkg::st_finish;
                end
            end
            sa_pkg::st_finish: state_nxt = sa_pkg::st_drain;
            sa_pkg::st_drain:  if (frame_end) state_nxt = sa_pkg::st_idle;
            default:           state_nxt = sa_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (sys_rst) begin
            state <= sa_pkg::st_idle;
            cnt   <= '0;
            done  <= 1'b0;
        end else begin
            state <= state_nxt;
            cnt   <= (state == sa_pkg::st_feed) ? cnt + sa_pkg::sa_idx_w'(1) : '0;
            done  <= (state == sa_pkg::st_drain) && frame_end; // cycle after last res_val
        end
    end

    // ####################
    // buffer read and lane drive
    // ####################
    assign busy   = (state != sa_pkg::st_idle);
    assign rd_en  = (state == sa_pkg::st_feed);
    assign rd_idx = cnt;

    assign feed.row_data = a_col;               // buffer returns zeros outside feed
    assign feed.col_data = b_row;
    assign feed.cal_en   = (state == sa_pkg::st_feed) || (state == sa_pkg::st_finish);
    assign feed.cal_done = (state == sa_pkg::st_finish);

    // a start during a run must not open a new feed
    a_start_only_idle: assert property (@(posedge clk) disable iff (sys_rst)
        start && (state != sa_pkg::st_idle) |=>
            !((state == sa_pkg::st_feed) && (cnt == '0)));

    a_drain_hold: assert property (@(posedge clk) disable iff (sys_rst)
        (state == sa_pkg::st_drain) && !frame_end |=> state == sa_pkg::st_drain);

endmodule

//--- design/sa_feed_if.sv
interface sa_feed_if;

    logic [sa_pkg::sa_n-1:0][sa_pkg::sa_in_w-1:0] row_data; // A lanes, one per array row
    logic [sa_pkg::sa_n-1:0][sa_pkg::sa_in_w-1:0] col_data; // B lanes, one per array column
    logic                                         cal_en;
    logic                                         cal_done;

    // controller side
    modport src (
        output row_data,
        output col_data,
        output cal_en,
        output cal_done
    );

    // skew stage input, taken from the controller side
    modport skew (
        input row_data,
        input col_data,
        input cal_en,
        input cal_done
    );

    modport pe (
        input row_data,
        input col_data,
        input cal_en,
        input cal_done
    );

endinterface

//--- design/sa_pkg.sv
package sa_pkg;

    // ####################
    // array geometry
    // ####################
    localparam int sa_n = 3;                     // matrix side and array side
    localparam int sa_idx_w = 2;                 // row / column index

    // ####################
    // datapath widths
    // ####################
    localparam int sa_in_w = 8;                  // unsigned operands
    localparam int sa_out_w = 20;                // three 16 bit products, no overflow
    localparam int sa_cnt_w = $clog2(sa_n * sa_n + 1); // results per frame

    // run controller
    typedef enum logic [1:0] {
        st_idle   = 2'd0,
        st_feed   = 2'd1,                        // one A column + one B row per cycle
        st_finish = 2'd2,                        // cal_done with zero lanes
        st_drain  = 2'd3                         // wait for the last result
    } sa_state_e;

endpackage

//--- design/sa_top.sv
module sa_top (
    input  logic                                          clk,
    input  logic                                          sys_rst,
    input  logic                                          wr,
    input  logic                                          wr_sel,
    input  logic [sa_pkg::sa_idx_w-1:0]                   wr_row,
    input  logic [sa_pkg::sa_idx_w-1:0]                   wr_col,
    input  logic [sa_pkg::sa_in_w-1:0]                    wr_data,
    input  logic                                          start,
    output logic                                          busy,
    output logic                                          done,
    output logic [sa_pkg::sa_n-1:0]                       res_val,
    output logic [sa_pkg::sa_n-1:0][sa_pkg::sa_idx_w-1:0] res_row,
    output logic [sa_pkg::sa_n-1:0][sa_pkg::sa_out_w-1:0] res_data
);

    logic [sa_pkg::sa_n-1:0][sa_pkg::sa_in_w-1:0]  a_col;
    logic [sa_pkg::sa_n-1:0][sa_pkg::sa_in_w-1:0]  b_row;
    logic [sa_pkg::sa_idx_w-1:0]                   rd_idx;
    logic                                          rd_en;
    logic                                          frame_end;
    logic [sa_pkg::sa_n-1:0]                       col_val;
    logic [sa_pkg::sa_n-1:0][sa_pkg::sa_out_w-1:0] col_data;

    sa_feed_if feed_raw ();                     // controller to skew stage
    sa_feed_if feed_skew ();                    // skew stage to array

    operand_buf i_operand_buf (
        .clk     (clk),
        .sys_rst (sys_rst),
        .wr      (wr),
        .wr_sel  (wr_sel),
        .wr_row  (wr_row),
        .wr_col  (wr_col),
        .wr_data (wr_data),
        .busy    (busy),
        .rd_idx  (rd_idx),
        .rd_en   (rd_en),
        .a_col   (a_col),
        .b_row   (b_row)
    );

    sa_ctrl i_sa_ctrl (
        .clk       (clk),
        .sys_rst   (sys_rst),
        .start     (start),
        .frame_end (frame_end),
        .a_col     (a_col),
        .b_row     (b_row),
        .busy      (busy),
        .done      (done),
        .rd_idx    (rd_idx),
        .rd_en     (rd_en),
        .feed      (feed_raw.src)
    );

    operand_skew i_operand_skew (
        .clk     (clk),
        .sys_rst (sys_rst),
        .in      (feed_raw.skew),
        .out     (feed_skew.src)
    );

    pe_array i_pe_array (
        .clk      (clk),
        .sys_rst  (sys_rst),
        .feed     (feed_skew.pe),
        .col_val  (col_val),
        .col_data (col_data)
    );

    result_collect i_result_collect (
        .clk       (clk),
        .sys_rst   (sys_rst),
        .col_val   (col_val),
        .col_data  (col_data),
        .res_val   (res_val),
        .res_row   (res_row),
        .res_data  (res_data),
        .frame_end (frame_end)
    );

endmodule

//--- sa_top.f
design/sa_pkg.sv
design/sa_feed_if.sv
design/pe_mac.sv
design/pe_array.sv
design/operand_buf.sv
design/operand_skew.sv
design/sa_ctrl.sv
design/result_collect.sv
design/sa_top.sv
test/tb_clk_gen.sv
test/tb_sa_top.sv

//--- test/tb_clk_gen.sv
module tb_clk_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always begin
        #50 clk = ~clk;                          // 100 unit period
    end

endmodule

//--- test/tb_sa_top.sv
module tb_sa_top;

    logic                                          clk;
    logic                                          sys_rst;
    logic                                          wr;
    logic                                          wr_sel;
    logic [sa_pkg::sa_idx_w-1:0]                   wr_row;
    logic [sa_pkg::sa_idx_w-1:0]                   wr_col;
    logic [sa_pkg::sa_in_w-1:0]                    wr_data;
    logic                                          start;
    logic                                          busy;
    logic                                          done;
    logic [sa_pkg::sa_n-1:0]                       res_val;
    logic [sa_pkg::sa_n-1:0][sa_pkg::sa_idx_w-1:0] res_row;
    logic [sa_pkg::sa_n-1:0][sa_pkg::sa_out_w-1:0] res_data;

    logic [sa_pkg::sa_in_w-1:0] mat_a [sa_pkg::sa_n][sa_pkg::sa_n]; // what the buffer should hold
    logic [sa_pkg::sa_in_w-1:0] mat_b [sa_pkg::sa_n][sa_pkg::sa_n];
    int                         seen  [sa_pkg::sa_n][sa_pkg::sa_n];
    int                         done_cnt;
    int                         errors;
    bit                         last_was_val;

    tb_clk_gen i_tb_clk_gen (.clk(clk));

    sa_top i_sa_top (
        .clk      (clk),
        .sys_rst  (sys_rst),
        .wr       (wr),
        .wr_sel   (wr_sel),
        .wr_row   (wr_row),
        .wr_col   (wr_col),
        .wr_data  (wr_data),
        .start    (start),
        .busy     (busy),
        .done     (done),
        .res_val  (res_val),
        .res_row  (res_row),
        .res_data (res_data)
    );

    // ####################
    // reference and compare
    // ####################
    function automatic logic [sa_pkg::sa_out_w-1:0] ref_elem(input int r, input int c);
        logic [sa_pkg::sa_out_w-1:0] acc;
        acc = '0;
        for (int k = 0; k < sa_pkg::sa_n; k++) begin
            acc = acc + sa_pkg::sa_out_w'(mat_a[r][k]) * sa_pkg::sa_out_w'(mat_b[k][c]);
        end
        return acc;
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("mismatch at %0t: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    // outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin : monitor
        int r;
        if (!sys_rst) begin
            if (done) begin
                done_cnt++;
                check_val("done after last res_val", 1, last_was_val);
            end
            for (int c = 0; c < sa_pkg::sa_n; c++) begin
                if (res_val[c]) begin
                    r = res_row[c];
                    if (done_cnt != 0) begin
                        errors++;
                        $display("result in column %0d arrived after done at %0t", c, $time);
                    end else if (r >= sa_pkg::sa_n) begin
                        errors++;
                        $display("row tag %0d out of range in column %0d at %0t", r, c, $time);
                    end else if (seen[r][c] != 0) begin
                        errors++;
                        $display("duplicate result for row %0d column %0d at %0t", r, c, $time);
                    end else begin
                        seen[r][c] = 1;
                        check_val($sformatf("res_data[%0d] row %0d", c, r), ref_elem(r, c),
                                  res_data[c]);
                    end
                end
            end
            last_was_val = |res_val;
        end
    end

    // ####################
    // host side tasks
    // ####################
    task automatic put(input bit sel, input int r, input int c,
                       input logic [sa_pkg::sa_in_w-1:0] d, input bit track);
        @(negedge clk);
        wr      = 1'b1;
        wr_sel  = sel;
        wr_row  = sa_pkg::sa_idx_w'(r);
        wr_col  = sa_pkg::sa_idx_w'(c);
        wr_data = d;
        @(negedge clk);
        wr = 1'b0;
        if (track && sel) begin
            mat_b[r][c] = d;
        end else if (track) begin
            mat_a[r][c] = d;
        end
    endtask

    // mode 0 random, 1 all ones, 2 identity, else a fixed pattern
    task automatic fill(input bit sel, input int mode);
        logic [sa_pkg::sa_in_w-1:0] d;
        for (int r = 0; r < sa_pkg::sa_n; r++) begin
            for (int c = 0; c < sa_pkg::sa_n; c++) begin
                case (mode)
                    0:       d = sa_pkg::sa_in_w'($urandom_range(0, 255));
                    1:       d = 8'hff;
                    2:       d = (r == c) ? 8'd1 : 8'd0;
                    default: d = sa_pkg::sa_in_w'((r * sa_pkg::sa_n + c + 1) * 11);
                endcase
                put(sel, r, c, d, 1'b1);
            end
        end
    endtask

    task automatic pulse_start();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic run(input bit late_write, input bit restart);
        int wait_cnt;
        foreach (seen[r, c]) begin
            seen[r][c] = 0;
        end
        done_cnt = 0;
        pulse_start();
        check_val("busy", 1, busy);
        if (late_write) begin
            put(1'b0, 0, 0, ~mat_a[0][0], 1'b0);   // buffer is frozen, model stays
        end
        if (restart) begin
            pulse_start();
        end
        wait_cnt = 0;
        while (done_cnt == 0 && wait_cnt < 200) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (done_cnt == 0) begin
            errors++;
            $display("timeout: no done pulse within 200 cycles at %0t", $time);
        end
        repeat (30) @(negedge clk);                // anything late shows up here
        check_val("done pulses", 1, done_cnt);
        foreach (seen[r, c]) begin
            if (seen[r][c] == 0) begin
                errors++;
                $display("missing result for row %0d column %0d", r, c);
            end
        end
        check_val("busy", 0, busy);
    endtask

    // ####################
    // stimulus
    // ####################
    initial begin
        void'($urandom(32'h1988));
        sys_rst  = 1'b1;
        wr       = 1'b0;
        wr_sel   = 1'b0;
        wr_row   = '0;
        wr_col   = '0;
        wr_data  = '0;
        start    = 1'b0;
        errors   = 0;
        done_cnt = 0;
        repeat (10) @(negedge clk);
        sys_rst = 1'b0;

        repeat (5) begin
            @(negedge clk);
            check_val("busy", 0, busy);
            check_val("done", 0, done);
            check_val("res_val", 0, res_val);
        end

        fill(1'b0, 3);                           // known A times identity
        fill(1'b1, 2);
        run(1'b0, 1'b0);

        for (int i = 0; i < 20; i++) begin
            fill(1'b0, (i == 0) ? 1 : 0);
            fill(1'b1, (i == 0) ? 1 : 0);
            run(1'b0, 1'b0);
        end

        fill(1'b0, 0);
        for (int i = 0; i < 3; i++) begin
            fill(1'b1, 0);                       // new B, same A
            run(1'b0, 1'b0);
        end

        run(1'b1, 1'b0);
        run(1'b0, 1'b0);
        run(1'b0, 1'b1);

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
